// ==== src/bfp_pkg.sv ====
package bfp_pkg;

  // lane count and bus packing.
  localparam int NUM_LANES      = 32;                 // fp32 lanes per block.
  localparam int CODES_PER_WORD = 4;                  // 8-bit codes per bus word.
  localparam int NUM_CODE_WORDS = NUM_LANES / CODES_PER_WORD;
  localparam int LANE_IDX_W     = $clog2(NUM_LANES);  // also the depth of the max tree.
  localparam int CODE_IDX_W     = $clog2(NUM_CODE_WORDS);

  // word address width of the slave.
  localparam int ADR_W = 6;

  // register map, word addresses.
  localparam logic [ADR_W-1:0] LANE_BASE  = 6'd0;   // lanes 0..31, read/write.
  localparam logic [ADR_W-1:0] SHEXP_ADDR = 6'd32;  // shared exponent, read only.
  localparam logic [ADR_W-1:0] CODE_BASE  = 6'd33;  // code words 33..40, read only.

  // shared exponent sits this far below the largest lane exponent.
  localparam logic [7:0] EXP_BIAS_SHIFT = 8'd15;

  // ieee single precision lane.
  typedef struct packed {
    logic        sign;
    logic [7:0]  exp;   // biased.
    logic [22:0] frac;
  } fp32_t;

  // quantized lane, one byte.
  typedef struct packed {
    logic       sign;
    logic [3:0] exp;   // relative to the shared exponent.
    logic [2:0] man;   // top fraction bits, rounded.
  } code_t;

  // one bus word, raw or as four codes.
  // codes[0] is the low byte, the lowest lane of the group.
  typedef union packed {
    logic [31:0]                    raw;
    code_t [CODES_PER_WORD-1:0]     codes;
  } result_word_u;

  // wishbone classic, master to slave.
  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic             we;
    logic [ADR_W-1:0] adr;  // word address.
    logic [31:0]      dat;  // write data.
  } wb_req_t;

  // wishbone classic, slave to master.
  typedef struct packed {
    logic        ack;
    logic [31:0] dat;  // read data, valid with ack.
  } wb_rsp_t;

endpackage

// ==== src/wb_lane_regs.sv ====
`timescale 1ns/1ps

module wb_lane_regs (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  bfp_pkg::wb_req_t      wb_req_i,
  output bfp_pkg::wb_rsp_t      wb_rsp_o,
  output bfp_pkg::fp32_t        lanes_o [bfp_pkg::NUM_LANES],
  input  logic [7:0]            shared_exp_i,
  input  bfp_pkg::code_t        codes_i [bfp_pkg::NUM_LANES]
);

  logic                          ack_q;     // single cycle ack.
  logic                          accept;    // new request seen this cycle.
  logic [bfp_pkg::ADR_W-1:0]     lane_off;  // address relative to the lane window.
  logic [bfp_pkg::ADR_W-1:0]     code_off;  // address relative to the code window.
  logic                          lane_hit;
  logic                          shexp_hit;
  logic                          code_hit;
  bfp_pkg::fp32_t                lanes_q [bfp_pkg::NUM_LANES];
  logic [7:0]                    shexp_q;   // captured shared exponent.
  bfp_pkg::code_t                codes_q [bfp_pkg::NUM_LANES];
  bfp_pkg::result_word_u         code_words [bfp_pkg::NUM_CODE_WORDS];
  logic [31:0]                   rd_word;   // read mux output.
  logic [31:0]                   rd_dat_q;  // read data held through ack.

  // a request is taken once, in the cycle before its ack.
  assign accept = wb_req_i.cyc & wb_req_i.stb & ~ack_q;

  // window decode by offset, so an address below a base wraps high and misses.
  assign lane_off  = wb_req_i.adr - bfp_pkg::LANE_BASE;
  assign code_off  = wb_req_i.adr - bfp_pkg::CODE_BASE;
  assign lane_hit  = (lane_off[bfp_pkg::ADR_W-1:bfp_pkg::LANE_IDX_W] == '0);  // 32 words.
  assign code_hit  = (code_off[bfp_pkg::ADR_W-1:bfp_pkg::CODE_IDX_W] == '0);  // 8 words.
  assign shexp_hit = (wb_req_i.adr == bfp_pkg::SHEXP_ADDR);

  // ack goes high for exactly one cycle per request.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= accept;
    end
  end

  // lane file, written at the edge that raises ack.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < bfp_pkg::NUM_LANES; i++) begin
        lanes_q[i] <= '0;
      end
    end else if (accept && wb_req_i.we && lane_hit) begin
      lanes_q[lane_off[bfp_pkg::LANE_IDX_W-1:0]] <= wb_req_i.dat;  // full word only.
    end
  end

  // results are sampled every clock.
  // they settle one edge after any lane write, and two edges into reset.
  always_ff @(posedge clk_i) begin
    shexp_q <= shared_exp_i;
    codes_q <= codes_i;
  end

  // four consecutive lanes per word, lowest lane in the low byte.
  for (genvar w = 0; w < bfp_pkg::NUM_CODE_WORDS; w++) begin : g_word
    for (genvar j = 0; j < bfp_pkg::CODES_PER_WORD; j++) begin : g_code
      assign code_words[w].codes[j] = codes_q[w*bfp_pkg::CODES_PER_WORD + j];
    end
  end

  // read mux.
  always_comb begin
    rd_word = '0;  // unmapped reads give zero.
    if (lane_hit) begin
      rd_word = lanes_q[lane_off[bfp_pkg::LANE_IDX_W-1:0]];
    end else if (shexp_hit) begin
      rd_word[7:0] = shexp_q;  // zero extended.
    end else if (code_hit) begin
      rd_word = code_words[code_off[bfp_pkg::CODE_IDX_W-1:0]].raw;
    end
  end

  // read data is sampled with the request and held while ack is high.
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rd_dat_q <= rd_word;
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rd_dat_q;
  assign lanes_o      = lanes_q;  // feeds the exponent tree and encoders.

endmodule

// ==== src/shared_exp_calc.sv ====
`timescale 1ns/1ps

module shared_exp_calc (
  input  bfp_pkg::fp32_t lanes_i [bfp_pkg::NUM_LANES],
  output logic [7:0]     shared_exp_o
);

  logic [7:0] max_exp;  // largest biased exponent over all lanes.

  // pairwise max tree.
  // level 0 holds the 32 lane exponents, each later level halves the count.
  // level LANE_IDX_W is the single survivor.
  for (genvar l = 0; l <= bfp_pkg::LANE_IDX_W; l++) begin : g_lvl
    logic [7:0] node [bfp_pkg::NUM_LANES >> l];  // survivors at this level.

    if (l == 0) begin : g_leaf
      // only the exponent field takes part.
      for (genvar i = 0; i < bfp_pkg::NUM_LANES; i++) begin : g_in
        assign node[i] = lanes_i[i].exp;
      end
    end else begin : g_max
      for (genvar i = 0; i < (bfp_pkg::NUM_LANES >> l); i++) begin : g_cmp
        // ties keep the left input.
        assign node[i] = (g_lvl[l-1].node[2*i] >= g_lvl[l-1].node[2*i+1]) ?
                         g_lvl[l-1].node[2*i] : g_lvl[l-1].node[2*i+1];
      end
    end
  end

  assign max_exp = g_lvl[bfp_pkg::LANE_IDX_W].node[0];

  // max minus 15, clamped at zero for small blocks.
  // a max of 15 or less gives zero, 16 gives one.
  assign shared_exp_o = (max_exp > bfp_pkg::EXP_BIAS_SHIFT) ?
                        (max_exp - bfp_pkg::EXP_BIAS_SHIFT) : 8'd0;

endmodule

// ==== src/lane_quantizer.sv ====
`timescale 1ns/1ps

module lane_quantizer (
  input  bfp_pkg::fp32_t lane_i,
  input  logic [7:0]     shared_exp_i,
  output bfp_pkg::code_t code_o
);

  logic       flush;     // magnitude too small for the block.
  logic [3:0] exp_diff;  // local exponent, at most 15 when not flushed.
  logic [3:0] man_sum;   // rounded mantissa with carry bit.

  // zero or denormal lanes flush, as do lanes under the shared exponent.
  assign flush = (lane_i.exp == 8'd0) || (lane_i.exp < shared_exp_i);

  // shared exponent is max minus 15, so the difference fits four bits.
  assign exp_diff = 4'(lane_i.exp - shared_exp_i);

  // round half up on the fourth fraction bit.
  assign man_sum = {1'b0, lane_i.frac[22:20]} + {3'b000, lane_i.frac[19]};

  always_comb begin
    code_o.sign = lane_i.sign;  // sign kept even when flushed.
    if (flush) begin
      code_o.exp = 4'd0;
      code_o.man = 3'd0;
    end else begin
      code_o.exp = exp_diff;
      // overflow pins at seven, no carry into the exponent.
      code_o.man = man_sum[3] ? 3'd7 : man_sum[2:0];
    end
  end

endmodule

// ==== src/bfp_quant_top.sv ====
`timescale 1ns/1ps

module bfp_quant_top (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  bfp_pkg::wb_req_t  wb_req_i,
  output bfp_pkg::wb_rsp_t  wb_rsp_o
);

  bfp_pkg::fp32_t lanes [bfp_pkg::NUM_LANES];  // registered lane file.
  logic [7:0]     shared_exp;                  // combinational, from the tree.
  bfp_pkg::code_t codes [bfp_pkg::NUM_LANES];  // combinational, one per lane.

  // bus slave, lane file and result capture.
  wb_lane_regs i_wb_lane_regs (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .wb_req_i     (wb_req_i),
    .wb_rsp_o     (wb_rsp_o),
    .lanes_o      (lanes),
    .shared_exp_i (shared_exp),
    .codes_i      (codes)
  );

  // max exponent tree.
  shared_exp_calc i_shared_exp_calc (
    .lanes_i      (lanes),
    .shared_exp_o (shared_exp)
  );

  // one encoder per lane, all against the same shared exponent.
  for (genvar i = 0; i < bfp_pkg::NUM_LANES; i++) begin : g_lane
    lane_quantizer i_lane_quantizer (
      .lane_i       (lanes[i]),
      .shared_exp_i (shared_exp),
      .code_o       (codes[i])
    );
  end

endmodule

// ==== bench/bfp_quant_sva.sv ====
`timescale 1ns/1ps

module bfp_quant_sva (
  input logic             clk_i,
  input logic             rst_n_i,
  input bfp_pkg::wb_req_t wb_req_i,
  input bfp_pkg::wb_rsp_t wb_rsp_i
);

  // ack answers a live request only.
  ack_needs_request: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $rose(wb_rsp_i.ack) |-> $past(wb_req_i.cyc && wb_req_i.stb)
  ) else $error("ack rose without cyc and stb high");

  // one cycle pulse per transfer.
  ack_single_cycle: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    wb_rsp_i.ack |=> !wb_rsp_i.ack
  ) else $error("ack high for two cycles in a row");

  // synchronous reset clears ack.
  ack_low_in_reset: assert property (
    @(posedge clk_i)
    !rst_n_i |=> !wb_rsp_i.ack
  ) else $error("ack high while reset is asserted");

endmodule

bind wb_lane_regs bfp_quant_sva i_bfp_quant_sva (
  .clk_i    (clk_i),
  .rst_n_i  (rst_n_i),
  .wb_req_i (wb_req_i),
  .wb_rsp_i (wb_rsp_o)
);

// ==== bench/bfp_quant_tb.sv ====
`timescale 1ns/1ps

module bfp_quant_tb;

  localparam int NUM_BLOCKS = 40;    // random blocks of 32 lane writes.
  // about 1,850 transactions at two cycles each give roughly 3,700 cycles.
  localparam int MAX_CYCLES = 8000;

  logic             clk;
  logic             rst_n;
  bfp_pkg::wb_req_t wb_req;
  bfp_pkg::wb_rsp_t wb_rsp;

  bfp_pkg::fp32_t model_lanes [bfp_pkg::NUM_LANES];  // what the DUT should hold.
  int errors = 0;
  int checks = 0;
  int cycles = 0;

  bfp_quant_top i_bfp_quant_top (
    .clk_i    (clk),
    .rst_n_i  (rst_n),
    .wb_req_i (wb_req),
    .wb_rsp_o (wb_rsp)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;  // 100 ns period.

  // run limit.
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d clock cycles.", MAX_CYCLES);
      $display("Verification failed");
      $finish;
    end
  end

  // ack must follow the request by exactly one cycle.
  task automatic check_ack_latency(input logic [5:0] adr, input int waits);
    checks++;
    if (waits != 1) begin
      errors++;
      $display("Error at %0t: ack for address %0d after %0d cycles, expected 1",
               $time, adr, waits);
    end
  endtask

  // wishbone classic write that holds the request until ack.
  task automatic bus_write(input logic [5:0] adr, input logic [31:0] dat);
    int waits;  // falling edges until ack.
    waits = 0;
    @(negedge clk);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = 1'b1;
    wb_req.adr = adr;
    wb_req.dat = dat;
    do begin
      @(negedge clk);
      waits++;
    end while (!wb_rsp.ack);
    wb_req.cyc = 1'b0;  // drop in the ack cycle.
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
    check_ack_latency(adr, waits);
  endtask

  // read that takes the data while ack is high.
  task automatic bus_read(input logic [5:0] adr, output logic [31:0] dat);
    int waits;  // falling edges until ack.
    waits = 0;
    @(negedge clk);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = 1'b0;
    wb_req.adr = adr;
    do begin
      @(negedge clk);
      waits++;
    end while (!wb_rsp.ack);
    dat = wb_rsp.dat;
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    check_ack_latency(adr, waits);
  endtask

  task automatic write_lane(input int idx, input bfp_pkg::fp32_t lane);
    bus_write(6'(int'(bfp_pkg::LANE_BASE) + idx), lane);
    model_lanes[idx] = lane;  // model follows the bus.
  endtask

  task automatic check_word(input string what, input logic [5:0] adr,
                            input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s, address %0d read %h, expected %h",
               $time, what, adr, got, exp);
    end
  endtask

  // largest exponent minus 15 or zero when the largest is below 16.
  function automatic logic [7:0] expected_shexp();
    int top;
    top = 0;
    for (int i = 0; i < bfp_pkg::NUM_LANES; i++) begin
      if (int'(model_lanes[i].exp) > top) begin
        top = int'(model_lanes[i].exp);
      end
    end
    if (top >= 16) return 8'(top - int'(bfp_pkg::EXP_BIAS_SHIFT));
    return 8'd0;
  endfunction

  function automatic bfp_pkg::code_t expected_code(input bfp_pkg::fp32_t lane, input int shexp);
    bfp_pkg::code_t c;
    int mant;
    c = '0;
    c.sign = lane.sign;  // signed zero on flush.
    if (lane.exp != 8'd0 && int'(lane.exp) >= shexp) begin
      c.exp = 4'(int'(lane.exp) - shexp);
      mant  = int'(lane.frac[22:20]) + int'(lane.frac[19]);  // half up.
      c.man = (mant > 7) ? 3'd7 : 3'(mant);                 // saturate.
    end
    return c;
  endfunction

  // shared exponent and all eight code words against the model.
  task automatic check_results(input string what);
    logic [31:0]           got;
    bfp_pkg::result_word_u word;
    bfp_pkg::code_t        exp_code;
    logic [7:0]            shexp;
    int                    lane_idx;
    shexp = expected_shexp();
    bus_read(bfp_pkg::SHEXP_ADDR, got);
    check_word({what, ", shared exponent"}, bfp_pkg::SHEXP_ADDR, got, {24'd0, shexp});
    for (int w = 0; w < bfp_pkg::NUM_CODE_WORDS; w++) begin
      bus_read(6'(int'(bfp_pkg::CODE_BASE) + w), word.raw);
      for (int j = 0; j < 4; j++) begin
        lane_idx = 4 * w + j;  // low byte is the lowest lane.
        exp_code = expected_code(model_lanes[lane_idx], int'(shexp));
        checks++;
        if (word.codes[j] !== exp_code) begin
          errors++;
          $display("Error at %0t: %s, lane %0d code %h, expected %h (lane %h, shexp %0d)",
                   $time, what, lane_idx, word.codes[j], exp_code,
                   model_lanes[lane_idx], shexp);
        end
      end
    end
  endtask

  initial begin
    logic [31:0]    got;
    bfp_pkg::fp32_t lane;
    int             top_exp;
    int             e;
    int             idx;
    void'($urandom(10503));
    wb_req = '0;
    rst_n  = 1'b0;
    for (int i = 0; i < bfp_pkg::NUM_LANES; i++) begin
      model_lanes[i] = '0;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // everything reads zero out of reset.
    for (int i = 0; i < bfp_pkg::NUM_LANES; i++) begin
      bus_read(6'(i), got);
      check_word("lane after reset", 6'(i), got, 32'd0);
    end
    check_results("after reset");

    // random blocks with exponents spread below a random maximum so some lanes flush.
    for (int b = 0; b < NUM_BLOCKS; b++) begin
      top_exp = int'($urandom_range(254, 1));
      for (int i = 0; i < bfp_pkg::NUM_LANES; i++) begin
        e = top_exp - int'($urandom_range(20, 0));
        if (e < 0) e = 0;
        lane.sign = 1'($urandom_range(1, 0));
        lane.exp  = 8'(e);
        lane.frac = 23'($urandom);
        write_lane(i, lane);
      end
      for (int k = 0; k < 2; k++) begin
        idx = int'($urandom_range(31, 0));
        bus_read(6'(idx), got);
        check_word("lane readback", 6'(idx), got, model_lanes[idx]);
      end
      check_results("random block");
    end

    // a max of 15 in the small block keeps the shared exponent at zero.
    for (int i = 0; i < bfp_pkg::NUM_LANES; i++) begin
      lane.sign = 1'($urandom_range(1, 0));
      lane.exp  = (i == 0) ? 8'd15 : (i == 1) ? 8'd0 : 8'($urandom_range(15, 1));
      lane.frac = 23'($urandom);
      write_lane(i, lane);
    end
    check_results("small block");

    // unmapped reads give zero.
    for (int a = 41; a < 64; a++) begin
      bus_read(6'(a), got);
      check_word("unmapped read", 6'(a), got, 32'd0);
    end
    // result words ignore writes.
    for (int a = 32; a <= 40; a++) begin
      bus_write(6'(a), $urandom);
    end
    check_results("after result writes");

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
src/bfp_pkg.sv
src/wb_lane_regs.sv
src/shared_exp_calc.sv
src/lane_quantizer.sv
src/bfp_quant_top.sv
bench/bfp_quant_sva.sv
bench/bfp_quant_tb.sv

// ==== Makefile ====
# Verilator flow for the block floating-point quantizer.
TOP := bfp_quant_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
	  echo "simulation reported failure, see $(LOG)"; \
	  exit 1; \
	fi
	@if ! grep -q "Verification passed" $(LOG); then \
	  echo "simulation ended without a result, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
